//--- run_sim.sh
#!/bin/sh
# build and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module conv_tb \
  -f sources.f -Mdir "$OBJ" -o conv_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/conv_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "result: FAIL"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "result: PASS"
exit 0

//--- sources.f
src/conv_pkg.sv
src/mac_cell.sv
src/mac_array.sv
src/input_skew.sv
src/conv_ctrl.sv
src/requant_out.sv
src/conv_top.sv
testbench/conv_props.sv
testbench/conv_tb.sv

//--- src/conv_ctrl.sv
`default_nettype none

module conv_ctrl import conv_pkg::*; #(
  parameter int TAPS    = 9,
  parameter int KERNELS = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   k_prefetch,
  input  logic                   if_start,
  input  logic                   act_valid,
  input  wload_t [KERNELS-1:0]   w_load,
  input  logic                   last_col_valid,
  output logic   [KERNELS-1:0]   w_shift,
  output logic                   act_accept,
  output logic                   of_done
);

  localparam int CNT_W = $clog2(TAPS + KERNELS + 2);

  ctrl_state_t      state;
  logic [CNT_W-1:0] cnt;       // vectors in flight
  logic [CNT_W-1:0] cnt_next;
  logic             drained;

  ////////////////////////////////////////////////////////////////////////////
  // strobe gating

  always_comb begin
    for (int k = 0; k < KERNELS; k++) begin
      w_shift[k] = w_load[k].valid && (state == ST_PREFETCH);
    end
  end

  assign act_accept = act_valid && (state == ST_CONV);

  ////////////////////////////////////////////////////////////////////////////
  // outstanding vector count

  always_comb begin
    cnt_next = cnt;
    if (act_accept && !last_col_valid) begin
      cnt_next = cnt + CNT_W'(1);
    end else if (!act_accept && last_col_valid) begin
      cnt_next = cnt - CNT_W'(1);
    end
  end

  assign drained = last_col_valid && (cnt_next == '0);

  ////////////////////////////////////////////////////////////////////////////
  // state machine

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      of_done <= 1'b0;
    end else begin
      cnt     <= cnt_next;
      of_done <= drained;
      case (state)
        ST_IDLE: begin
          if (if_start) state <= ST_CONV;
          else if (k_prefetch) state <= ST_PREFETCH;
        end
        ST_PREFETCH: begin
          if (if_start) state <= ST_CONV;
        end
        ST_CONV: begin
          if (drained) state <= ST_IDLE;  // last beat out
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/conv_pkg.sv
`default_nettype none

package conv_pkg;

  localparam int ACT_W    = 16;
  localparam int ACT_FRAC = 8;
  localparam int WGT_W    = 8;
  localparam int WGT_FRAC = 6;
  localparam int ACC_W    = 40;  // 2*ACT_W + WGT_W
  localparam int ACC_FRAC = 14;
  localparam int OUT_W    = 16;
  localparam int OUT_FRAC = 8;

  localparam int QUANT_SHIFT = ACC_FRAC - OUT_FRAC;

  typedef logic signed [ACT_W-1:0] act_t;
  typedef logic signed [WGT_W-1:0] wgt_t;
  typedef logic signed [ACC_W-1:0] acc_t;
  typedef logic signed [OUT_W-1:0] out_t;

  localparam out_t OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};
  localparam out_t OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};

  // one kernel's weight lane
  typedef struct packed {
    logic valid;
    wgt_t data;
  } wload_t;

  // one kernel's result lane
  typedef struct packed {
    logic valid;
    out_t data;
  } out_beat_t;

  typedef enum logic [1:0] {ST_IDLE, ST_PREFETCH, ST_CONV} ctrl_state_t;

endpackage

`default_nettype wire

//--- src/conv_top.sv
`default_nettype none

module conv_top import conv_pkg::*; #(
  parameter int TAPS    = 9,
  parameter int KERNELS = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      k_prefetch,
  input  logic                      if_start,
  input  logic                      act_valid,
  input  act_t      [TAPS-1:0]      act_in,
  input  wload_t    [KERNELS-1:0]   w_load,
  output out_beat_t [KERNELS-1:0]   of_out,
  output logic                      of_done
);

  logic [KERNELS-1:0] w_shift;
  wgt_t [KERNELS-1:0] w_data;
  logic               act_accept;
  act_t [TAPS-1:0]    row_act;
  logic [TAPS-1:0]    row_valid;
  acc_t [KERNELS-1:0] col_sum;
  logic [KERNELS-1:0] col_valid;

  for (genvar k = 0; k < KERNELS; k++) begin : g_wdata
    assign w_data[k] = w_load[k].data;
  end

  ////////////////////////////////////////////////////////////////////////////

  conv_ctrl #(
    .TAPS    (TAPS),
    .KERNELS (KERNELS)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .k_prefetch     (k_prefetch),
    .if_start       (if_start),
    .act_valid      (act_valid),
    .w_load         (w_load),
    .last_col_valid (of_out[KERNELS-1].valid),  // done tracking
    .w_shift        (w_shift),
    .act_accept     (act_accept),
    .of_done        (of_done)
  );

  input_skew #(
    .TAPS (TAPS)
  ) u_skew (
    .clk        (clk),
    .rst        (rst),
    .act_accept (act_accept),
    .act_in     (act_in),
    .row_act    (row_act),
    .row_valid  (row_valid)
  );

  mac_array #(
    .TAPS    (TAPS),
    .KERNELS (KERNELS)
  ) u_array (
    .clk       (clk),
    .rst       (rst),
    .w_shift   (w_shift),
    .w_data    (w_data),
    .row_act   (row_act),
    .row_valid (row_valid),
    .col_sum   (col_sum),
    .col_valid (col_valid)
  );

  requant_out #(
    .KERNELS (KERNELS)
  ) u_requant (
    .clk       (clk),
    .rst       (rst),
    .col_sum   (col_sum),
    .col_valid (col_valid),
    .of_out    (of_out)
  );

endmodule

`default_nettype wire

//--- src/input_skew.sv
`default_nettype none

module input_skew import conv_pkg::*; #(
  parameter int TAPS = 9
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              act_accept,
  input  act_t [TAPS-1:0]   act_in,
  output act_t [TAPS-1:0]   row_act,
  output logic [TAPS-1:0]   row_valid
);

  // row r gets r+1 register stages
  for (genvar r = 0; r < TAPS; r++) begin : g_row
    act_t       dly [r+1];
    logic [r:0] vld;

    always_ff @(posedge clk) begin
      dly[0] <= act_in[r];
      for (int i = 1; i <= r; i++) dly[i] <= dly[i-1];
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        vld <= '0;
      end else begin
        vld[0] <= act_accept;  // strobe rides with the data
        for (int i = 1; i <= r; i++) vld[i] <= vld[i-1];
      end
    end

    assign row_act[r]   = dly[r];
    assign row_valid[r] = vld[r];
  end

endmodule

`default_nettype wire

//--- src/mac_array.sv
`default_nettype none

module mac_array import conv_pkg::*; #(
  parameter int TAPS    = 9,
  parameter int KERNELS = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [KERNELS-1:0]   w_shift,
  input  wgt_t [KERNELS-1:0]   w_data,
  input  act_t [TAPS-1:0]      row_act,
  input  logic [TAPS-1:0]      row_valid,
  output acc_t [KERNELS-1:0]   col_sum,
  output logic [KERNELS-1:0]   col_valid
);

  wgt_t wgt_q [TAPS][KERNELS];
  act_t act_q [TAPS][KERNELS];
  logic vld_q [TAPS][KERNELS];
  acc_t psum  [TAPS][KERNELS];

  for (genvar r = 0; r < TAPS; r++) begin : g_row
    for (genvar k = 0; k < KERNELS; k++) begin : g_col
      wgt_t w_src;
      act_t a_src;
      logic v_src;
      acc_t p_src;

      if (r == 0) begin : g_top
        assign w_src = w_data[k];
        assign p_src = '0;  // no bias
      end else begin : g_inner
        assign w_src = wgt_q[r-1][k];
        assign p_src = psum[r-1][k];
      end

      if (k == 0) begin : g_left
        assign a_src = row_act[r];
        assign v_src = row_valid[r];
      end else begin : g_right
        assign a_src = act_q[r][k-1];
        assign v_src = vld_q[r][k-1];
      end

      mac_cell u_cell (
        .clk           (clk),
        .rst           (rst),
        .w_shift       (w_shift[k]),
        .w_in          (w_src),
        .w_out         (wgt_q[r][k]),
        .act_in        (a_src),
        .act_valid_in  (v_src),
        .act_out       (act_q[r][k]),
        .act_valid_out (vld_q[r][k]),
        .psum_in       (p_src),
        .psum_out      (psum[r][k])
      );
    end
  end

  // bottom row carries the finished sums
  for (genvar k = 0; k < KERNELS; k++) begin : g_out
    assign col_sum[k]   = psum[TAPS-1][k];
    assign col_valid[k] = vld_q[TAPS-1][k];
  end

endmodule

`default_nettype wire

//--- src/mac_cell.sv
`default_nettype none

module mac_cell import conv_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic w_shift,
  input  wgt_t w_in,
  output wgt_t w_out,
  input  act_t act_in,
  input  logic act_valid_in,
  output act_t act_out,
  output logic act_valid_out,
  input  acc_t psum_in,
  output acc_t psum_out
);

  logic signed [ACT_W+WGT_W-1:0] prod;

  // w_out is the stationary weight
  assign prod = (ACT_W+WGT_W)'(act_in) * (ACT_W+WGT_W)'(w_out);

  always_ff @(posedge clk) begin
    if (rst) begin
      w_out         <= '0;
      act_valid_out <= 1'b0;
      psum_out      <= '0;
    end else begin
      if (w_shift) w_out <= w_in;  // serial load down the column
      act_valid_out <= act_valid_in;
      psum_out      <= psum_in + acc_t'(prod);
    end
  end

  always_ff @(posedge clk) begin
    act_out <= act_in;
  end

endmodule

`default_nettype wire

//--- src/requant_out.sv
`default_nettype none

module requant_out import conv_pkg::*; #(
  parameter int KERNELS = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  acc_t      [KERNELS-1:0]   col_sum,
  input  logic      [KERNELS-1:0]   col_valid,
  output out_beat_t [KERNELS-1:0]   of_out
);

  for (genvar k = 0; k < KERNELS; k++) begin : g_col
    acc_t               sum;
    acc_t               shifted;
    logic [ACC_W-OUT_W:0] top;
    logic               in_range;
    out_t               sat;
    logic               vld_q;
    out_t               data_q;

    assign sum      = col_sum[k];
    assign shifted  = sum >>> QUANT_SHIFT;  // drop 6 fraction bits
    assign top      = shifted[ACC_W-1:OUT_W-1];
    assign in_range = (&top) | ~(|top);  // all sign copies
    assign sat      = in_range ? shifted[OUT_W-1:0] :
                      (shifted[ACC_W-1] ? OUT_MIN : OUT_MAX);

    always_ff @(posedge clk) begin
      if (rst) vld_q <= 1'b0;
      else vld_q <= col_valid[k];
    end

    always_ff @(posedge clk) begin
      if (col_valid[k]) data_q <= sat;
    end

    assign of_out[k].valid = vld_q;
    assign of_out[k].data  = data_q;
  end

endmodule

`default_nettype wire

//--- testbench/conv_props.sv
`default_nettype none

module conv_props import conv_pkg::*; #(
  parameter int TAPS    = 9,
  parameter int KERNELS = 3
) (
  input logic        clk,
  input logic        rst,
  input ctrl_state_t state,
  input logic        act_accept,
  input logic        last_col_valid,
  input logic        of_done
);

  // last column beat is sampled this many edges after its accept
  localparam int LAST_LAG = TAPS + KERNELS + 1;

  a_done_single: assert property (@(posedge clk) disable iff (rst)
    of_done |=> !of_done)
    else $error("of_done stayed high for more than one cycle");

  a_no_beat_in_prefetch: assert property (@(posedge clk) disable iff (rst)
    (state == ST_PREFETCH) |-> !last_col_valid)
    else $error("output beat while loading weights");

  a_beat_has_vector: assert property (@(posedge clk) disable iff (rst)
    last_col_valid |-> $past(act_accept, LAST_LAG))
    else $error("output beat without an accepted vector at the right lag");

endmodule

bind conv_ctrl conv_props #(
  .TAPS    (TAPS),
  .KERNELS (KERNELS)
) u_props (
  .clk            (clk),
  .rst            (rst),
  .state          (state),
  .act_accept     (act_accept),
  .last_col_valid (last_col_valid),
  .of_done        (of_done)
);

`default_nettype wire

//--- testbench/conv_tb.sv
`default_nettype none

module conv_tb import conv_pkg::*; ();

  localparam int TAPS      = 9;
  localparam int KERNELS   = 3;
  localparam int DRAIN     = TAPS + KERNELS + 1;  // accept to done pulse
  localparam int N_IDLE    = 6;
  localparam int N_B2B     = 40;
  localparam int N_SAT     = 12;
  localparam int N_RAND    = 24;
  localparam int N_WHOLD   = 16;
  localparam int ROUNDS    = 5;
  localparam int TOTAL_VEC = N_IDLE + 1 + N_B2B + N_SAT + N_RAND + N_WHOLD;
  localparam int TIMEOUT   = 10 + 4 * TOTAL_VEC + ROUNDS * (TAPS + DRAIN + 8) + 200;

  typedef struct packed {
    int   due;  // cycle count at which the beat is seen
    out_t data;
  } exp_beat_t;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    k_prefetch;
  logic                    if_start;
  logic                    act_valid;
  act_t      [TAPS-1:0]    act_in;
  wload_t    [KERNELS-1:0] w_load;
  out_beat_t [KERNELS-1:0] of_out;
  logic                    of_done;

  exp_beat_t   exp_q [KERNELS][$];
  wgt_t        wm [KERNELS][TAPS];  // model weight chains with row 0 first
  ctrl_state_t mstate;
  int          mcnt;
  int          done_at;
  int          cyc = 0;
  int          done_cnt = 0;
  logic [31:0] lfsr;

  conv_top #(
    .TAPS    (TAPS),
    .KERNELS (KERNELS)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .k_prefetch (k_prefetch),
    .if_start   (if_start),
    .act_valid  (act_valid),
    .act_in     (act_in),
    .w_load     (w_load),
    .of_out     (of_out),
    .of_done    (of_done)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  always @(posedge clk) begin
    if (cyc > TIMEOUT) begin
      $display("timeout: no end of test after %0d cycles", TIMEOUT);
      $display("sim failed");
      $fatal(1, "run did not finish in time");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check(input string what, input longint got, input longint exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s, got %0d, expected %0d", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic longint dot(input int k);
    longint s;
    s = '0;
    for (int r = 0; r < TAPS; r++) begin
      s += longint'(act_in[r]) * longint'(wm[k][r]);
    end
    return s;
  endfunction

  function automatic out_t requant(input longint sum);
    longint q;
    q = sum >>> (ACC_FRAC - OUT_FRAC);
    if (q > 64'sd32767) return 16'sh7fff;
    else if (q < -64'sd32768) return 16'sh8000;
    else return out_t'(q);
  endfunction

  task automatic drive_quiet();
    k_prefetch <= 1'b0;
    if_start   <= 1'b0;
    act_valid  <= 1'b0;
    for (int k = 0; k < KERNELS; k++) begin
      w_load[k].valid <= 1'b0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      drive_quiet();
    end
  endtask

  task automatic pulse_prefetch();
    @(posedge clk);
    drive_quiet();
    k_prefetch <= 1'b1;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    drive_quiet();
    if_start <= 1'b1;
  endtask

  // extreme sets kernel 0 to +127 and kernel 1 to -128 throughout
  task automatic load_weights(input bit extreme);
    logic [31:0] b;
    repeat (TAPS) begin
      @(posedge clk);
      drive_quiet();
      for (int k = 0; k < KERNELS; k++) begin
        b = rand_bits(8);
        w_load[k].valid <= 1'b1;
        if (!extreme) w_load[k].data <= wgt_t'(b[7:0]);
        else if (k == 0) w_load[k].data <= wgt_t'(8'h7f);
        else if (k == 1) w_load[k].data <= wgt_t'(8'h80);
        else w_load[k].data <= b[0] ? wgt_t'(8'h7f) : wgt_t'(8'h80);
      end
    end
  endtask

  task automatic send_vector(input bit big, input bit wnoise);
    logic [31:0] b;
    logic        neg;
    @(posedge clk);
    drive_quiet();
    b   = rand_bits(1);
    neg = b[0];  // one sign for the whole vector when big
    act_valid <= 1'b1;
    for (int r = 0; r < TAPS; r++) begin
      if (big) begin
        b = rand_bits(8);
        act_in[r] <= neg ? act_t'(-32768 + int'(b)) : act_t'(32767 - int'(b));
      end else begin
        b = rand_bits(12);
        act_in[r] <= act_t'(int'(b) - 2048);
      end
    end
    for (int k = 0; k < KERNELS; k++) begin
      b = rand_bits(9);
      w_load[k].valid <= wnoise & b[8];
      w_load[k].data  <= wgt_t'(b[7:0]);
    end
  endtask

  task automatic send_vectors(input int n, input bit gaps, input bit big, input bit wnoise);
    logic [31:0] b;
    for (int i = 0; i < n; i++) begin
      if (gaps) begin
        b = rand_bits(2);
        idle_cycles(int'(b));
      end
      send_vector(big, wnoise);
    end
  endtask

  task automatic wait_done(input int target);
    while (done_cnt < target) begin
      @(posedge clk);
      drive_quiet();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output checks and reference model sampled mid-cycle

  always @(negedge clk) begin : monitor
    logic [KERNELS-1:0] due_now;
    logic               accept;
    int                 next_cnt;
    exp_beat_t          beat;
    if (!rst) begin
      for (int k = 0; k < KERNELS; k++) begin
        due_now[k] = (exp_q[k].size() > 0) && (exp_q[k][0].due == cyc);
        check($sformatf("kernel %0d valid at cycle %0d", k, cyc),
              longint'(of_out[k].valid), longint'(due_now[k]));
        if (due_now[k]) begin
          check($sformatf("kernel %0d data at cycle %0d", k, cyc),
                longint'($signed(of_out[k].data)), longint'(exp_q[k][0].data));
          void'(exp_q[k].pop_front());
        end
      end
      check($sformatf("of_done at cycle %0d", cyc), longint'(of_done),
            longint'(done_at == cyc));
      if (of_done) done_cnt++;

      // inputs seen now are taken at the next edge
      accept   = (mstate == ST_CONV) && act_valid;
      next_cnt = mcnt + int'(accept) - int'(due_now[KERNELS-1]);
      for (int k = 0; k < KERNELS; k++) begin
        if (accept) begin
          beat.due  = cyc + TAPS + k + 2;
          beat.data = requant(dot(k));
          exp_q[k].push_back(beat);
        end
        if (mstate == ST_PREFETCH && w_load[k].valid) begin
          for (int r = TAPS - 1; r > 0; r--) begin
            wm[k][r] = wm[k][r-1];
          end
          wm[k][0] = w_load[k].data;
        end
      end
      mcnt = next_cnt;
      case (mstate)
        ST_IDLE: begin
          if (if_start) mstate = ST_CONV;
          else if (k_prefetch) mstate = ST_PREFETCH;
        end
        ST_PREFETCH: begin
          if (if_start) mstate = ST_CONV;
        end
        default: begin
          if (due_now[KERNELS-1] && next_cnt == 0) begin
            mstate  = ST_IDLE;
            done_at = cyc + 1;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    lfsr    = 32'd71670;
    mstate  = ST_IDLE;
    mcnt    = 0;
    done_at = -1;
    for (int k = 0; k < KERNELS; k++) begin
      for (int r = 0; r < TAPS; r++) begin
        wm[k][r] = '0;
      end
    end
    rst    <= 1'b1;
    act_in <= '0;
    w_load <= '0;
    drive_quiet();
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    idle_cycles(4);
    send_vectors(N_IDLE, 1'b1, 1'b0, 1'b1);  // dropped while idle
    idle_cycles(DRAIN + 4);

    pulse_prefetch();
    load_weights(1'b0);
    pulse_start();
    send_vectors(1, 1'b0, 1'b0, 1'b0);
    wait_done(1);

    pulse_start();  // same weights with vectors every cycle
    send_vectors(N_B2B, 1'b0, 1'b0, 1'b0);
    wait_done(2);

    pulse_prefetch();
    load_weights(1'b1);
    pulse_start();
    send_vectors(N_SAT, 1'b1, 1'b1, 1'b0);
    wait_done(3);

    pulse_prefetch();
    load_weights(1'b0);
    pulse_start();
    send_vectors(N_RAND, 1'b1, 1'b0, 1'b0);
    wait_done(4);

    pulse_start();  // weight strobes during conv must be ignored
    send_vectors(N_WHOLD, 1'b1, 1'b0, 1'b1);
    wait_done(5);
    idle_cycles(DRAIN + 4);

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
